// File: rtl/aos_pkg.sv
// Shared types and constants for the host soft-register path.
// Soft-register addresses carry the host byte address unchanged.
// Each slot holds eight 64-bit registers selected by address bits 5:3.
// The slot index starts at address bit 6 and is sized by NUM_APPS.

package aos_pkg;

	// --------------------------------------------------
	// Bus widths
	// --------------------------------------------------
	typedef logic [31:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [31:0] sr_addr_t;
	typedef logic [63:0] sr_data_t;

	// --------------------------------------------------
	// Soft-register request and response
	// --------------------------------------------------
	// 98 bits in total
	typedef struct packed {
		logic     valid;
		logic     is_write;
		sr_addr_t addr;
		sr_data_t data;
	} softreg_req_t;

	// 65 bits in total
	typedef struct packed {
		logic     valid;
		sr_data_t data;
	} softreg_resp_t;

	// --------------------------------------------------
	// Address fields
	// --------------------------------------------------
	localparam int REG_IDX_BITS = 3;
	localparam int SLOT_LSB = 6;
	// Register index sits just below the slot index
	localparam int REG_LSB = SLOT_LSB - REG_IDX_BITS;
	localparam int NUM_SLOT_REGS = 1 << REG_IDX_BITS;

	// Returned for reads of a slot whose enable is low
	localparam sr_data_t DISABLED_READ_DATA = '1;

	// Host bridge control states
	typedef enum logic [1:0] {
		IDLE,
		WR_RESP,
		RD_WAIT,
		RD_RESP
	} bridge_state_t;

endpackage

// File: rtl/rst_pipe.sv
// Reset synchronizer for the whole shell.
// The external rst_n is sampled on global_clk, so a reset pulse must
// last at least one clock. Release reaches the output two clocks later.

`timescale 1ns/100ps

module rst_pipe (
	input  logic global_clk,
	input  logic rst_n,
	output logic rst_sync_n
);

	logic [1:0] sync_q;

	// Clear on reset, then shift ones in
	always_ff @(posedge global_clk) begin
		if (!rst_n) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[0], 1'b1};
		end
	end

	assign rst_sync_n = sync_q[1];

endmodule

// File: rtl/axil_softreg_bridge.sv
// AXI-Lite slave to soft-register bridge.
// Handles one transaction at a time and a write wins over a read.
// A write needs awvalid and wvalid in the same cycle; wstrb is ignored and
// the whole 64-bit register is written with wdata zero-extended.
// Reads return the low 32 bits. bresp and rresp are always OKAY.
// Writes are posted; bvalid rises without waiting for the slot.

`timescale 1ns/100ps

module axil_softreg_bridge (
	input  logic                   global_clk,
	input  logic                   rst_n,

	// Write address
	input  logic                   awvalid,
	input  aos_pkg::axil_addr_t    awaddr,
	output logic                   awready,

	// Write data
	input  logic                   wvalid,
	input  aos_pkg::axil_data_t    wdata,
	input  logic [3:0]             wstrb,
	output logic                   wready,

	// Write response
	output logic                   bvalid,
	output logic [1:0]             bresp,
	input  logic                   bready,

	// Read address
	input  logic                   arvalid,
	input  aos_pkg::axil_addr_t    araddr,
	output logic                   arready,

	// Read data
	output logic                   rvalid,
	output aos_pkg::axil_data_t    rdata,
	output logic [1:0]             rresp,
	input  logic                   rready,

	// Soft-register side
	output aos_pkg::softreg_req_t  softreg_req,
	input  aos_pkg::softreg_resp_t softreg_resp
);

	import aos_pkg::*;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	bridge_state_t state_q;
	logic          wr_accept;
	logic          rd_accept;

	logic          req_vld_q;
	logic          req_is_write_q;
	sr_addr_t      req_addr_q;
	sr_data_t      req_data_q;
	axil_data_t    rdata_q;

	// --------------------------------------------------
	// Channel handshakes
	// --------------------------------------------------
	assign awready = (state_q == IDLE);
	assign wready  = (state_q == IDLE);
	assign arready = (state_q == IDLE);

	assign wr_accept = (state_q == IDLE) && awvalid && wvalid;
	// Read only goes when no complete write is offered
	assign rd_accept = (state_q == IDLE) && arvalid && !wr_accept;

	assign bvalid = (state_q == WR_RESP);
	assign bresp  = RESP_OKAY;
	assign rvalid = (state_q == RD_RESP);
	assign rresp  = RESP_OKAY;
	assign rdata  = rdata_q;

	// --------------------------------------------------
	// Control FSM
	// --------------------------------------------------
	always_ff @(posedge global_clk) begin
		if (!rst_n) begin
			state_q   <= IDLE;
			req_vld_q <= 1'b0;
		end else begin
			// Request valid is a single-cycle strobe
			req_vld_q <= wr_accept || rd_accept;
			case (state_q)
				IDLE: begin
					if (wr_accept) begin
						state_q <= WR_RESP;
					end else if (rd_accept) begin
						state_q <= RD_WAIT;
					end
				end
				WR_RESP: begin
					if (bready) begin
						state_q <= IDLE;
					end
				end
				RD_WAIT: begin
					if (softreg_resp.valid) begin
						state_q <= RD_RESP;
					end
				end
				RD_RESP: begin
					if (rready) begin
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Request payload and read data capture
	always_ff @(posedge global_clk) begin
		if (wr_accept) begin
			req_is_write_q <= 1'b1;
			req_addr_q     <= awaddr;
			req_data_q     <= {32'b0, wdata};
		end else if (rd_accept) begin
			req_is_write_q <= 1'b0;
			req_addr_q     <= araddr;
			req_data_q     <= '0;
		end
		if ((state_q == RD_WAIT) && softreg_resp.valid) begin
			rdata_q <= softreg_resp.data[31:0];
		end
	end

	assign softreg_req = '{
		valid:    req_vld_q,
		is_write: req_is_write_q,
		addr:     req_addr_q,
		data:     req_data_q
	};

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	// Only the one outstanding read may come back
	resp_only_in_rd_wait: assert property (
		@(posedge global_clk) disable iff (!rst_n)
		softreg_resp.valid |-> (state_q == RD_WAIT)
	);

	bvalid_held_until_bready: assert property (
		@(posedge global_clk) disable iff (!rst_n)
		(bvalid && !bready) |=> bvalid
	);

endmodule

// File: rtl/softreg_pipe.sv
// Register pipeline for soft-register requests or responses.
// Latency is exactly STAGES clocks, with STAGES of at least 1.
// Every stage clears to zero on reset, so no valid bit survives it.

`timescale 1ns/100ps

module softreg_pipe #(
	parameter int  STAGES = 2,
	parameter type T      = logic
) (
	input  logic global_clk,
	input  logic rst_n,
	input  T     in_bus,
	output T     out_bus
);

	T stage_q [STAGES];

	always_ff @(posedge global_clk) begin
		if (!rst_n) begin
			for (int i = 0; i < STAGES; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= in_bus;
			// Shift toward the output
			for (int i = 1; i < STAGES; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign out_bus = stage_q[STAGES-1];

endmodule

// File: rtl/softreg_router.sv
// Routes host soft-register requests to NUM_APPS application slots.
// Slot index is taken from the address above bit SLOT_LSB; higher bits ignored.
// The enable level is sampled when the request arrives. Requests to a
// disabled slot are dropped, and reads to it are answered here with all ones.
// Expects at most one read in flight, as the host bridge guarantees.

`timescale 1ns/100ps

module softreg_router #(
	parameter int NUM_APPS = 4
) (
	input  logic                   global_clk,
	input  logic                   rst_n,
	input  logic [NUM_APPS-1:0]    app_enable,

	// Host side
	input  aos_pkg::softreg_req_t  host_req,
	output aos_pkg::softreg_resp_t host_resp,

	// Slot side
	output aos_pkg::softreg_req_t  app_req [NUM_APPS],
	input  aos_pkg::softreg_resp_t app_resp [NUM_APPS]
);

	import aos_pkg::*;

	localparam int SLOT_BITS = $clog2(NUM_APPS);

	logic [SLOT_BITS-1:0] host_slot;
	logic                 slot_on;

	logic [NUM_APPS-1:0]  req_vld_q;
	logic                 req_is_write_q;
	sr_addr_t             req_addr_q;
	sr_data_t             req_data_q;

	logic                 dis_rd_q;
	logic                 dis_rd_qq;

	logic [NUM_APPS-1:0]  resp_vld_vec;
	sr_data_t             resp_data_or;
	logic                 resp_vld_q;
	sr_data_t             resp_data_q;

	assign host_slot = host_req.addr[SLOT_LSB +: SLOT_BITS];
	assign slot_on   = app_enable[host_slot];

	// --------------------------------------------------
	// Request fan-out
	// --------------------------------------------------
	always_ff @(posedge global_clk) begin
		if (!rst_n) begin
			req_vld_q <= '0;
			dis_rd_q  <= 1'b0;
			dis_rd_qq <= 1'b0;
		end else begin
			for (int i = 0; i < NUM_APPS; i++) begin
				req_vld_q[i] <= host_req.valid && (host_slot == SLOT_BITS'(i)) && app_enable[i];
			end
			// Local answer for a disabled read, two stages so it lines
			// up with where a slot response would enter the merge
			dis_rd_q  <= host_req.valid && !host_req.is_write && !slot_on;
			dis_rd_qq <= dis_rd_q;
		end
	end

	// Shared payload, only the valids are per slot
	always_ff @(posedge global_clk) begin
		if (host_req.valid) begin
			req_is_write_q <= host_req.is_write;
			req_addr_q     <= host_req.addr;
			req_data_q     <= host_req.data;
		end
	end

	for (genvar g = 0; g < NUM_APPS; g++) begin : fan
		assign app_req[g] = '{
			valid:    req_vld_q[g],
			is_write: req_is_write_q,
			addr:     req_addr_q,
			data:     req_data_q
		};
		assign resp_vld_vec[g] = app_resp[g].valid;
	end

	// --------------------------------------------------
	// Response merge
	// --------------------------------------------------
	always_comb begin
		resp_data_or = dis_rd_qq ? DISABLED_READ_DATA : '0;
		for (int i = 0; i < NUM_APPS; i++) begin
			if (app_resp[i].valid) begin
				resp_data_or = resp_data_or | app_resp[i].data;
			end
		end
	end

	always_ff @(posedge global_clk) begin
		if (!rst_n) begin
			resp_vld_q <= 1'b0;
		end else begin
			resp_vld_q <= (|resp_vld_vec) || dis_rd_qq;
		end
	end

	always_ff @(posedge global_clk) begin
		resp_data_q <= resp_data_or;
	end

	assign host_resp = '{valid: resp_vld_q, data: resp_data_q};

	// OR merge is only safe with a single source per cycle
	one_resp_source: assert property (
		@(posedge global_clk) disable iff (!rst_n)
		$onehot0({dis_rd_qq, resp_vld_vec})
	);

endmodule

// File: rtl/app_scratch_slot.sv
// Scratch register bank standing in for one application's control registers.
// Registers 0 to 6 are read/write; register 7 reads SLOT_ID and ignores writes.
// The router has already matched the slot, so only bits 5:3 are decoded here.

`timescale 1ns/100ps

module app_scratch_slot #(
	parameter int SLOT_ID = 0
) (
	input  logic                   global_clk,
	input  logic                   rst_n,
	input  aos_pkg::softreg_req_t  softreg_req,
	output aos_pkg::softreg_resp_t softreg_resp
);

	import aos_pkg::*;

	localparam logic [REG_IDX_BITS-1:0] ID_REG = REG_IDX_BITS'(NUM_SLOT_REGS - 1);

	logic [REG_IDX_BITS-1:0] reg_idx;
	sr_data_t                regs_q [NUM_SLOT_REGS-1];
	logic                    resp_vld_q;
	sr_data_t                resp_data_q;

	assign reg_idx = softreg_req.addr[REG_LSB +: REG_IDX_BITS];

	// --------------------------------------------------
	// Register writes and read valid
	// --------------------------------------------------
	always_ff @(posedge global_clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_SLOT_REGS - 1; i++) begin
				regs_q[i] <= '0;
			end
			resp_vld_q <= 1'b0;
		end else begin
			if (softreg_req.valid && softreg_req.is_write && (reg_idx != ID_REG)) begin
				regs_q[reg_idx] <= softreg_req.data;
			end
			// One response per read, none for writes
			resp_vld_q <= softreg_req.valid && !softreg_req.is_write;
		end
	end

	// Read data
	always_ff @(posedge global_clk) begin
		if (softreg_req.valid && !softreg_req.is_write) begin
			if (reg_idx == ID_REG) begin
				resp_data_q <= sr_data_t'(SLOT_ID);
			end else begin
				resp_data_q <= regs_q[reg_idx];
			end
		end
	end

	assign softreg_resp = '{valid: resp_vld_q, data: resp_data_q};

endmodule

// File: rtl/aos_shell_top.sv
// Host register path of the shell.
// AXI-Lite slave -> bridge -> request pipe -> router -> NUM_APPS slots,
// with responses back through the router and a response pipe.
// NUM_APPS must be a power of two from 2 to 16; PIPE_STAGES at least 1.
// A read takes 2*PIPE_STAGES+5 clocks from acceptance to rvalid.
// rst_n is synchronized internally and takes two clocks to release.

`timescale 1ns/100ps

module aos_shell_top #(
	parameter int NUM_APPS    = 4,
	parameter int PIPE_STAGES = 2
) (
	input  logic                global_clk,
	input  logic                rst_n,

	// AXI-Lite slave
	input  logic                awvalid,
	input  aos_pkg::axil_addr_t awaddr,
	output logic                awready,
	input  logic                wvalid,
	input  aos_pkg::axil_data_t wdata,
	input  logic [3:0]          wstrb,
	output logic                wready,
	output logic                bvalid,
	output logic [1:0]          bresp,
	input  logic                bready,
	input  logic                arvalid,
	input  aos_pkg::axil_addr_t araddr,
	output logic                arready,
	output logic                rvalid,
	output aos_pkg::axil_data_t rdata,
	output logic [1:0]          rresp,
	input  logic                rready,

	// Per-slot enable level
	input  logic [NUM_APPS-1:0] app_enable
);

	import aos_pkg::*;

	logic          rst_sync_n;

	softreg_req_t  bridge_req;
	softreg_req_t  router_req;
	softreg_resp_t router_resp;
	softreg_resp_t bridge_resp;

	softreg_req_t  slot_req [NUM_APPS];
	softreg_resp_t slot_resp [NUM_APPS];

	// --------------------------------------------------
	// Reset
	// --------------------------------------------------
	rst_pipe rp (
		.global_clk (global_clk),
		.rst_n      (rst_n),
		.rst_sync_n (rst_sync_n)
	);

	// --------------------------------------------------
	// Host bridge
	// --------------------------------------------------
	axil_softreg_bridge bridge (
		.global_clk   (global_clk),
		.rst_n        (rst_sync_n),
		.awvalid      (awvalid),
		.awaddr       (awaddr),
		.awready      (awready),
		.wvalid       (wvalid),
		.wdata        (wdata),
		.wstrb        (wstrb),
		.wready       (wready),
		.bvalid       (bvalid),
		.bresp        (bresp),
		.bready       (bready),
		.arvalid      (arvalid),
		.araddr       (araddr),
		.arready      (arready),
		.rvalid       (rvalid),
		.rdata        (rdata),
		.rresp        (rresp),
		.rready       (rready),
		.softreg_req  (bridge_req),
		.softreg_resp (bridge_resp)
	);

	// --------------------------------------------------
	// Buffering between bridge and router
	// --------------------------------------------------
	softreg_pipe #(.STAGES(PIPE_STAGES), .T(softreg_req_t)) req_pipe (
		.global_clk (global_clk),
		.rst_n      (rst_sync_n),
		.in_bus     (bridge_req),
		.out_bus    (router_req)
	);

	softreg_pipe #(.STAGES(PIPE_STAGES), .T(softreg_resp_t)) resp_pipe (
		.global_clk (global_clk),
		.rst_n      (rst_sync_n),
		.in_bus     (router_resp),
		.out_bus    (bridge_resp)
	);

	// --------------------------------------------------
	// Router and slots
	// --------------------------------------------------
	softreg_router #(.NUM_APPS(NUM_APPS)) router (
		.global_clk (global_clk),
		.rst_n      (rst_sync_n),
		.app_enable (app_enable),
		.host_req   (router_req),
		.host_resp  (router_resp),
		.app_req    (slot_req),
		.app_resp   (slot_resp)
	);

	for (genvar g = 0; g < NUM_APPS; g++) begin : slot
		app_scratch_slot #(.SLOT_ID(g)) app (
			.global_clk   (global_clk),
			.rst_n        (rst_sync_n),
			.softreg_req  (slot_req[g]),
			.softreg_resp (slot_resp[g])
		);
	end

endmodule

// File: bench/tb_clk_gen.sv
// Clock and reset source for the testbench.
// 10 ns clock period. rst_n is low for four rising edges and
// is released on the following falling edge.

`timescale 1ns/100ps

module tb_clk_gen (
	output logic global_clk,
	output logic rst_n
);

	initial begin
		global_clk = 1'b0;
		forever begin
			#5 global_clk = ~global_clk;
		end
	end

	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge global_clk);
		@(negedge global_clk);
		rst_n = 1'b1;
	end

endmodule

// File: bench/tb_aos_shell.sv
// Testbench for the host soft-register path of the shell.
// Runs with NUM_APPS = 4 and PIPE_STAGES = 2.
// Inputs change on the falling edge and outputs are sampled there too.
// Read data is compared with a register model; the host sees the low 32 bits.
// One transaction at a time and enables only change while the DUT is idle.

`timescale 1ns/100ps

module tb_aos_shell;

	import aos_pkg::*;

	localparam int NUM_APPS       = 4;
	localparam int PIPE_STAGES    = 2;
	localparam int SLOT_BITS      = $clog2(NUM_APPS);
	localparam int NUM_REGS       = 8;
	localparam int READ_LATENCY   = 2 * PIPE_STAGES + 5;
	localparam int TIMEOUT_CYCLES = 100;

	logic                global_clk;
	logic                rst_n;
	logic                awvalid;
	axil_addr_t          awaddr;
	logic                awready;
	logic                wvalid;
	axil_data_t          wdata;
	logic [3:0]          wstrb;
	logic                wready;
	logic                bvalid;
	logic [1:0]          bresp;
	logic                bready;
	logic                arvalid;
	axil_addr_t          araddr;
	logic                arready;
	logic                rvalid;
	axil_data_t          rdata;
	logic [1:0]          rresp;
	logic                rready;
	logic [NUM_APPS-1:0] app_enable;

	// Register model and enables as the host sees them
	sr_data_t            model_regs [NUM_APPS][NUM_REGS];
	logic [NUM_APPS-1:0] model_en;

	// Issued reads waiting for rvalid
	axil_data_t          exp_q [$];
	int                  hold_q [$];
	int                  accept_q [$];

	int   cyc = 0;
	int   reads_done = 0;
	int   checks = 0;
	int   errors = 0;
	int   tests_run = 0;
	int   tests_failed = 0;
	int   test_err_base = 0;
	logic rready_idle = 1'b0;
	logic bready_idle = 1'b0;
	logic check_latency = 1'b0;
	event abort_ev;

	tb_clk_gen clk_gen (
		.global_clk (global_clk),
		.rst_n      (rst_n)
	);

	aos_shell_top #(.NUM_APPS(NUM_APPS), .PIPE_STAGES(PIPE_STAGES)) dut (
		.global_clk (global_clk),
		.rst_n      (rst_n),
		.awvalid    (awvalid),
		.awaddr     (awaddr),
		.awready    (awready),
		.wvalid     (wvalid),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wready     (wready),
		.bvalid     (bvalid),
		.bresp      (bresp),
		.bready     (bready),
		.arvalid    (arvalid),
		.araddr     (araddr),
		.arready    (arready),
		.rvalid     (rvalid),
		.rdata      (rdata),
		.rresp      (rresp),
		.rready     (rready),
		.app_enable (app_enable)
	);

	always @(posedge global_clk) begin
		cyc <= cyc + 1;
	end

	// --------------------------------------------------
	// Checks and reporting
	// --------------------------------------------------
	function automatic void check_bit(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endfunction

	function automatic void check_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endfunction

	function automatic void print_counts();
		$display("Summary: %0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
	endfunction

	function automatic void end_test(input string name);
		tests_run++;
		if (errors == test_err_base) begin
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: FAILED with %0d errors", name, errors - test_err_base);
		end
		test_err_base = errors;
	endfunction

	task automatic timed_out(input string what);
		$display("Timeout at t=%0t: no %s within %0d cycles", $time, what, TIMEOUT_CYCLES);
		-> abort_ev;
	endtask

	task automatic check_idle_outputs();
		check_bit("bvalid", bvalid, 1'b0);
		check_bit("rvalid", rvalid, 1'b0);
		check_bit("awready", awready, 1'b1);
		check_bit("wready", wready, 1'b1);
		check_bit("arready", arready, 1'b1);
	endtask

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	function automatic axil_addr_t reg_addr(input int slot, input int idx);
		axil_addr_t a;
		// Random bits above the slot field
		a = $urandom();
		a[SLOT_LSB +: SLOT_BITS] = SLOT_BITS'(slot);
		a[5:3] = 3'(idx);
		a[2:0] = 3'b000;
		return a;
	endfunction

	function automatic axil_data_t expected_rdata(input axil_addr_t addr);
		int slot;
		int idx;
		slot = int'(addr[SLOT_LSB +: SLOT_BITS]);
		idx  = int'(addr[5:3]);
		if (!model_en[slot]) begin
			return 32'hffff_ffff;
		end
		if (idx == NUM_REGS - 1) begin
			return axil_data_t'(slot);
		end
		return model_regs[slot][idx][31:0];
	endfunction

	function automatic void model_write(input axil_addr_t addr, input axil_data_t data);
		int slot;
		int idx;
		slot = int'(addr[SLOT_LSB +: SLOT_BITS]);
		idx  = int'(addr[5:3]);
		// Disabled slots drop writes and the ID register is read-only
		if (model_en[slot] && idx != NUM_REGS - 1) begin
			model_regs[slot][idx] = {32'h0, data};
		end
	endfunction

	// --------------------------------------------------
	// Host transactions
	// --------------------------------------------------
	task automatic axil_write(input axil_addr_t addr, input axil_data_t data, input int hold);
		int n;
		int i;
		awvalid = 1'b1;
		awaddr  = addr;
		wvalid  = 1'b1;
		wdata   = data;
		// Any strobe pattern still writes the whole register
		wstrb   = 4'($urandom());
		n = 0;
		while (!(awready && wready)) begin
			@(negedge global_clk);
			n++;
			if (n > TIMEOUT_CYCLES) begin
				timed_out("write accept");
				return;
			end
		end
		// Accepted at the coming rising edge
		@(negedge global_clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		model_write(addr, data);
		n = 0;
		while (!bvalid) begin
			@(negedge global_clk);
			n++;
			if (n > TIMEOUT_CYCLES) begin
				timed_out("bvalid");
				return;
			end
		end
		if (hold > 0) begin
			bready = 1'b0;
		end
		for (i = 0; i < hold; i++) begin
			check_bit("bvalid", bvalid, 1'b1);
			check_bit("awready", awready, 1'b0);
			check_bit("wready", wready, 1'b0);
			check_bit("arready", arready, 1'b0);
			@(negedge global_clk);
		end
		bready = 1'b1;
		check_bit("bvalid", bvalid, 1'b1);
		check_word("bresp", 32'(bresp), 32'd0);
		@(negedge global_clk);
		check_bit("bvalid", bvalid, 1'b0);
		bready = bready_idle;
	endtask

	task automatic axil_read(input axil_addr_t addr, input int hold);
		int n;
		int target;
		target  = reads_done + 1;
		arvalid = 1'b1;
		araddr  = addr;
		n = 0;
		while (!arready) begin
			@(negedge global_clk);
			n++;
			if (n > TIMEOUT_CYCLES) begin
				timed_out("arready");
				return;
			end
		end
		exp_q.push_back(expected_rdata(addr));
		hold_q.push_back(hold);
		accept_q.push_back(cyc);
		@(negedge global_clk);
		arvalid = 1'b0;
		n = 0;
		while (reads_done < target) begin
			@(negedge global_clk);
			n++;
			if (n > TIMEOUT_CYCLES) begin
				timed_out("read data handshake");
				return;
			end
		end
	endtask

	task automatic read_all_regs(input int hold);
		int s;
		int r;
		for (s = 0; s < NUM_APPS; s++) begin
			for (r = 0; r < NUM_REGS; r++) begin
				axil_read(reg_addr(s, r), hold);
			end
		end
	endtask

	// --------------------------------------------------
	// Read data compare that also drives rready
	// --------------------------------------------------
	initial begin : compare_reads
		logic       busy;
		int         hold_left;
		int         acc;
		axil_data_t held;
		axil_data_t expected;
		busy      = 1'b0;
		hold_left = 0;
		acc       = 0;
		held      = '0;
		rready    = 1'b0;
		forever begin
			@(negedge global_clk);
			if (rvalid) begin
				check_bit("awready", awready, 1'b0);
				check_bit("wready", wready, 1'b0);
				check_bit("arready", arready, 1'b0);
				if (!busy) begin
					busy = 1'b1;
					hold_left = 0;
					held = rdata;
					assert (exp_q.size() > 0) else begin
						errors++;
						$display("Unexpected rvalid at t=%0t with no read outstanding", $time);
					end
					if (exp_q.size() > 0) begin
						expected  = exp_q.pop_front();
						hold_left = hold_q.pop_front();
						acc       = accept_q.pop_front();
						check_word("rdata", rdata, expected);
						check_word("rresp", 32'(rresp), 32'd0);
						if (check_latency) begin
							check_word("read latency", 32'(cyc - acc), 32'(READ_LATENCY));
						end
					end
				end else begin
					// Held data must not move before the handshake
					check_word("rdata", rdata, held);
				end
				if (hold_left > 0) begin
					rready = 1'b0;
					hold_left--;
				end else begin
					rready = 1'b1;
				end
			end else begin
				if (busy) begin
					if (!rready) begin
						check_bit("rvalid", rvalid, 1'b1);
					end
					busy = 1'b0;
					reads_done++;
				end
				rready = rready_idle;
			end
		end
	end

	initial begin : abort_on_timeout
		@(abort_ev);
		print_counts();
		$display("Regression failed");
		$finish;
	end

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	initial begin : stimulus
		int         i;
		int         s;
		int         r;
		int         n;
		int         dis_slot;
		axil_addr_t addr;
		axil_addr_t pending [$];

		void'($urandom(32'h3934_5a66));
		awvalid    = 1'b0;
		awaddr     = '0;
		wvalid     = 1'b0;
		wdata      = '0;
		wstrb      = 4'h0;
		bready     = 1'b0;
		arvalid    = 1'b0;
		araddr     = '0;
		app_enable = '1;
		model_en   = '1;
		for (s = 0; s < NUM_APPS; s++) begin
			for (r = 0; r < NUM_REGS; r++) begin
				model_regs[s][r] = '0;
			end
		end

		// Reset values once the internal reset has settled
		repeat (2) @(negedge global_clk);
		n = 0;
		while (!rst_n) begin
			check_idle_outputs();
			@(negedge global_clk);
			n++;
			if (n > TIMEOUT_CYCLES) begin
				timed_out("reset release");
				break;
			end
		end
		repeat (4) begin
			check_idle_outputs();
			@(negedge global_clk);
		end
		read_all_regs(0);
		end_test("reset");

		// Random writes that are read back later
		for (i = 0; i < 40; i++) begin
			addr = reg_addr($urandom_range(NUM_APPS - 1, 0), $urandom_range(6, 0));
			axil_write(addr, $urandom(), 0);
			pending.push_back(addr);
			if (pending.size() > 2 || $urandom_range(1, 0) == 1) begin
				axil_read(pending.pop_front(), 0);
			end
		end
		while (pending.size() > 0) begin
			axil_read(pending.pop_front(), 0);
		end
		// Full sweep shows no write leaked elsewhere
		read_all_regs(0);
		end_test("write_read");

		// ID register ignores writes
		for (s = 0; s < NUM_APPS; s++) begin
			axil_write(reg_addr(s, NUM_REGS - 1), $urandom(), 0);
			axil_read(reg_addr(s, NUM_REGS - 1), 0);
			axil_read(reg_addr(s, NUM_REGS - 2), 0);
		end
		end_test("id_reg");

		// One slot disabled and then enabled again
		dis_slot = $urandom_range(NUM_APPS - 1, 0);
		model_en[dis_slot] = 1'b0;
		app_enable = model_en;
		@(negedge global_clk);
		for (r = 0; r < NUM_REGS; r++) begin
			axil_read(reg_addr(dis_slot, r), 0);
		end
		for (r = 0; r < NUM_REGS - 1; r++) begin
			axil_write(reg_addr(dis_slot, r), $urandom(), 0);
		end
		axil_read(reg_addr((dis_slot + 1) % NUM_APPS, 0), 0);
		model_en[dis_slot] = 1'b1;
		app_enable = model_en;
		@(negedge global_clk);
		for (r = 0; r < NUM_REGS; r++) begin
			axil_read(reg_addr(dis_slot, r), 0);
		end
		end_test("disabled_slot");

		// Random stalls on the response channels
		for (i = 0; i < 20; i++) begin
			addr = reg_addr($urandom_range(NUM_APPS - 1, 0), $urandom_range(6, 0));
			axil_write(addr, $urandom(), $urandom_range(10, 0));
			axil_read(addr, $urandom_range(10, 0));
			axil_read(reg_addr($urandom_range(NUM_APPS - 1, 0), $urandom_range(7, 0)),
				$urandom_range(10, 0));
		end
		end_test("backpressure");

		// Read latency with both readies held high
		bready_idle = 1'b1;
		rready_idle = 1'b1;
		bready = 1'b1;
		check_latency = 1'b1;
		@(negedge global_clk);
		for (i = 0; i < 8; i++) begin
			addr = reg_addr($urandom_range(NUM_APPS - 1, 0), $urandom_range(7, 0));
			axil_write(addr, $urandom(), 0);
			axil_read(addr, 0);
		end
		check_latency = 1'b0;
		bready_idle = 1'b0;
		rready_idle = 1'b0;
		bready = 1'b0;
		end_test("read_latency");

		repeat (2) @(negedge global_clk);
		print_counts();
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: flist.f
rtl/aos_pkg.sv
rtl/rst_pipe.sv
rtl/axil_softreg_bridge.sv
rtl/softreg_pipe.sv
rtl/softreg_router.sv
rtl/app_scratch_slot.sv
rtl/aos_shell_top.sv
bench/tb_clk_gen.sv
bench/tb_aos_shell.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
# The result comes from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
MDIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_aos_shell \
	--Mdir "$MDIR" -o tb_sim \
	-f flist.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$MDIR/tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0
